/* all.f */
+incdir+include
logic/fp16Pkg.sv
logic/accumCtrlPkg.sv
logic/fpAlignStage.sv
logic/fpMantissaAddStage.sv
logic/fpNormalizeStage.sv
logic/fpRoundStage.sv
logic/accumSequencer.sv
logic/halfVectorAccum.sv
test/tbHalfVectorAccum.sv

/* include/accum_settings.svh */
`ifndef ACCUM_SETTINGS_SVH
`define ACCUM_SETTINGS_SVH

// Run length, words per start
`define ACCUM_LEN 8

// binary16 layout
`define HALF_W 16
`define EXP_W 5
`define MANT_W 10

`define ADDR_W 3 // Memory address bits
`define GUARD_W 3 // Extra low bits kept through alignment
`define ADD_LATENCY 4 // One register per adder stage

// Derived datapath widths
`define ALIGN_W (`MANT_W + `GUARD_W + 1) // hidden + mantissa + guard bits
`define SUM_W (`ALIGN_W + 2) // carry + aligned + sticky

`endif

/* logic/accumCtrlPkg.sv */
`include "accum_settings.svh"

package accumCtrlPkg;

	// Sequencer states
	typedef enum logic [1:0] {
		stIdle, // waiting for start
		stRead, // memory enable high
		stCapture, // read data on the bus
		stWait // adder in flight
	} seqState_t;

	typedef logic [`ADDR_W-1:0] memAddr_t;

	// One bit wider than the address, reaches ACCUM_LEN
	typedef logic [`ADDR_W:0] elemIndex_t;

endpackage

/* logic/accumSequencer.sv */
`include "accum_settings.svh"

module accumSequencer (
	input logic ap_clk,
	input logic ap_rst,
	input logic start,
	input logic continueRun,
	output logic done,
	output logic idle,
	output logic ready,
	output accumCtrlPkg::memAddr_t memAddr,
	output logic memEnable,
	input fp16Pkg::halfWord_t memData,
	output fp16Pkg::halfWord_t opA,
	output fp16Pkg::halfWord_t opB,
	output logic issue,
	input fp16Pkg::halfWord_t sum,
	input logic sumValid,
	output fp16Pkg::halfWord_t result,
	output logic resultValid
);
	import fp16Pkg::*;
	import accumCtrlPkg::*;

	seqState_t state;
	elemIndex_t index;
	logic [$clog2(`ADD_LATENCY)-1:0] waitCnt;
	logic doneReg; // held until continue
	logic accept;
	logic finish; // read state past the last element
	halfWord_t sumReg; // running sum
	halfWord_t loadWord;
	halfWord_t resultReg;

	assign accept = (state == stIdle) && start && !doneReg;
	assign finish = (state == stRead) && (index == elemIndex_t'(`ACCUM_LEN));

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= stIdle;
			index <= '0;
			waitCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (accept) begin
						state <= stRead;
						index <= '0;
					end
				end
				stRead: state <= finish ? stIdle : stCapture;
				stCapture: begin
					state <= stWait;
					waitCnt <= '0;
				end
				stWait: begin
					waitCnt <= waitCnt + 1'b1;
					if (waitCnt == $bits(waitCnt)'(`ADD_LATENCY - 1)) begin
						state <= stRead; // sum arrives with the next read
						index <= index + 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge ap_clk) begin
		if (accept)
			sumReg <= '0; // +0 start value
		else if (sumValid)
			sumReg <= sum;
		if (state == stCapture)
			loadWord <= memData; // word returned for the read
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			doneReg <= 1'b0;
			resultReg <= '0;
		end else begin
			if (continueRun)
				doneReg <= 1'b0;
			else if (finish)
				doneReg <= 1'b1;
			if (finish)
				resultReg <= sum;
		end
	end

	assign memEnable = (state == stRead) && !finish;
	assign memAddr = index[`ADDR_W-1:0];

	// One add in flight, issued on the first wait cycle
	assign issue = (state == stWait) && (waitCnt == '0);
	assign opA = sumReg;
	assign opB = loadWord;

	assign done = finish | doneReg;
	assign ready = finish;
	assign idle = (state == stIdle) && !start;
	assign resultValid = finish;
	assign result = finish ? sum : resultReg; // Fresh sum in the done cycle

endmodule

/* logic/fp16Pkg.sv */
`include "accum_settings.svh"

package fp16Pkg;

	// Full half word
	typedef struct packed {
		logic sign;
		logic [`EXP_W-1:0] exp;
		logic [`MANT_W-1:0] mant;
	} halfWord_t;

	typedef struct packed {
		logic [`EXP_W-1:0] exp;
		logic [`MANT_W-1:0] mant;
	} halfFields_t;

	// Unsigned part, compared whole or split into fields
	typedef union packed {
		logic [`HALF_W-2:0] mag; // ordering view
		halfFields_t fields; // alignment view
	} halfMag_u;

	typedef logic [`MANT_W:0] sigMant_t; // Hidden one on top
	typedef logic [`ALIGN_W-1:0] alignMant_t;
	typedef logic [`SUM_W-1:0] wideMant_t;

	// Align -> add
	typedef struct packed {
		logic [`EXP_W-1:0] exp; // larger operand's exponent
		logic signBig;
		logic signSmall;
		sigMant_t mantBig;
		alignMant_t mantSmall; // shifted, guard bits below
		logic sticky; // OR of everything shifted out
	} alignedOp_t;

	// Add -> normalize
	typedef struct packed {
		logic sign;
		logic bothNeg; // both operands negative
		logic [`EXP_W-1:0] exp;
		wideMant_t sum;
	} mantSum_t;

	// Normalize -> round
	typedef struct packed {
		logic sign;
		logic bothNeg;
		logic [`EXP_W-1:0] exp;
		logic [`MANT_W-1:0] mant; // hidden one dropped
		logic guard;
		logic round;
		logic sticky;
		logic zero; // whole sum was zero
	} normSum_t;

endpackage

/* logic/fpAlignStage.sv */
`include "accum_settings.svh"

module fpAlignStage (
	input logic ap_clk,
	input fp16Pkg::halfWord_t opA,
	input fp16Pkg::halfWord_t opB,
	input logic issue,
	output fp16Pkg::alignedOp_t aligned,
	output logic alignedValid
);
	import fp16Pkg::*;

	halfMag_u magA;
	halfMag_u magB;
	halfMag_u magBig;
	halfMag_u magSmall;
	logic swap;
	logic [`EXP_W-1:0] expDiff;
	sigMant_t sigBig;
	sigMant_t sigSmall;
	logic [2*`ALIGN_W-1:0] shiftWin; // Upper half kept, lower half is sticky
	alignedOp_t alignNext;

	assign magA = opA[`HALF_W-2:0];
	assign magB = opB[`HALF_W-2:0];

	// B strictly larger, ties keep A on top
	assign swap = magA.mag < magB.mag;
	assign magBig = swap ? magB : magA;
	assign magSmall = swap ? magA : magB;

	assign expDiff = magBig.fields.exp - magSmall.fields.exp;

	// Zero exponent means a zero operand, no hidden one
	assign sigBig = {|magBig.fields.exp, magBig.fields.mant};
	assign sigSmall = {|magSmall.fields.exp, magSmall.fields.mant};

	assign shiftWin = {sigSmall, {(`ALIGN_W + `GUARD_W){1'b0}}} >> expDiff;

	always_comb begin
		alignNext.exp = magBig.fields.exp;
		alignNext.signBig = swap ? opB.sign : opA.sign;
		alignNext.signSmall = swap ? opA.sign : opB.sign;
		alignNext.mantBig = sigBig;
		if (expDiff > (`MANT_W + `GUARD_W)) begin
			// Smaller operand entirely below the guard bits
			alignNext.mantSmall = '0;
			alignNext.sticky = |sigSmall;
		end else begin
			alignNext.mantSmall = shiftWin[2*`ALIGN_W-1:`ALIGN_W];
			alignNext.sticky = |shiftWin[`ALIGN_W-1:0];
		end
	end

	always_ff @(posedge ap_clk) begin
		aligned <= alignNext;
		alignedValid <= issue;
	end

endmodule

/* logic/fpMantissaAddStage.sv */
`include "accum_settings.svh"

module fpMantissaAddStage (
	input logic ap_clk,
	input fp16Pkg::alignedOp_t aligned,
	input logic alignedValid,
	output fp16Pkg::mantSum_t mantSum,
	output logic mantSumValid
);
	import fp16Pkg::*;

	wideMant_t bigWide;
	wideMant_t smallWide;
	wideMant_t sumWide;
	logic effSub; // signs differ, so subtract

	// Same bit weights for both, sticky in the LSB of the smaller
	assign bigWide = {1'b0, aligned.mantBig, {(`GUARD_W + 1){1'b0}}};
	assign smallWide = {1'b0, aligned.mantSmall, aligned.sticky};

	assign effSub = aligned.signBig ^ aligned.signSmall;

	// Larger minus smaller never goes negative
	assign sumWide = effSub ? bigWide - smallWide : bigWide + smallWide;

	always_ff @(posedge ap_clk) begin
		mantSum.sign <= aligned.signBig; // larger operand decides
		mantSum.bothNeg <= aligned.signBig & aligned.signSmall;
		mantSum.exp <= aligned.exp;
		mantSum.sum <= sumWide;
		mantSumValid <= alignedValid;
	end

endmodule

/* logic/fpNormalizeStage.sv */
`include "accum_settings.svh"

module fpNormalizeStage (
	input logic ap_clk,
	input fp16Pkg::mantSum_t mantSum,
	input logic mantSumValid,
	output fp16Pkg::normSum_t normSum,
	output logic normValid
);
	import fp16Pkg::*;

	typedef logic [$clog2(`SUM_W)-1:0] shAmt_t;

	wideMant_t sumIn;
	wideMant_t shifted; // Hidden one lands at SUM_W-2
	shAmt_t lead;
	shAmt_t lz;
	logic [`EXP_W-1:0] expNext;
	normSum_t normNext;

	assign sumIn = mantSum.sum;

	// Priority encoder, highest set bit wins
	always_comb begin
		lead = '0;
		for (int i = 0; i < `SUM_W; i++) begin
			if (sumIn[i])
				lead = shAmt_t'(i);
		end
	end

	assign lz = shAmt_t'(`SUM_W - 2) - lead;

	always_comb begin
		if (sumIn[`SUM_W-1]) begin
			// Carry out, one step right, dropped bit joins sticky
			shifted = {1'b0, sumIn[`SUM_W-1:2], sumIn[1] | sumIn[0]};
			expNext = mantSum.exp + 1'b1;
		end else begin
			shifted = sumIn << lz; // cancellation, pull leading one up
			expNext = mantSum.exp - `EXP_W'(lz);
		end
	end

	always_comb begin
		normNext.sign = mantSum.sign;
		normNext.bothNeg = mantSum.bothNeg;
		normNext.exp = expNext;
		normNext.mant = shifted[`SUM_W-3:`GUARD_W+1];
		normNext.guard = shifted[`GUARD_W];
		normNext.round = shifted[`GUARD_W-1];
		normNext.sticky = |shifted[`GUARD_W-2:0];
		normNext.zero = ~|sumIn;
	end

	always_ff @(posedge ap_clk) begin
		normSum <= normNext;
		normValid <= mantSumValid;
	end

endmodule

/* logic/fpRoundStage.sv */
`include "accum_settings.svh"

module fpRoundStage (
	input logic ap_clk,
	input fp16Pkg::normSum_t normSum,
	input logic normValid,
	output fp16Pkg::halfWord_t sum,
	output logic sumValid
);
	import fp16Pkg::*;

	logic roundUp;
	logic [`MANT_W:0] mantUp; // Extra bit catches the mantissa carry
	halfWord_t sumNext;

	// Nearest even, ties go to the even mantissa
	assign roundUp = normSum.guard & (normSum.round | normSum.sticky | normSum.mant[0]);
	assign mantUp = {1'b0, normSum.mant} + 1'b1;

	always_comb begin
		sumNext.sign = normSum.sign;
		sumNext.exp = normSum.exp;
		sumNext.mant = normSum.mant;
		if (normSum.zero) begin
			// Only -0 plus -0 keeps the minus
			sumNext.sign = normSum.bothNeg;
			sumNext.exp = '0;
			sumNext.mant = '0;
		end else if (roundUp) begin
			sumNext.mant = mantUp[`MANT_W-1:0]; // wraps to zero on carry
			sumNext.exp = normSum.exp + `EXP_W'(mantUp[`MANT_W]);
		end
	end

	always_ff @(posedge ap_clk) begin
		sum <= sumNext;
		sumValid <= normValid;
	end

endmodule

/* logic/halfVectorAccum.sv */
module halfVectorAccum (
	input logic ap_clk,
	input logic ap_rst,
	input logic start,
	input logic continueRun,
	output logic done,
	output logic idle,
	output logic ready,
	output accumCtrlPkg::memAddr_t memAddr,
	output logic memEnable,
	input fp16Pkg::halfWord_t memData,
	output fp16Pkg::halfWord_t result,
	output logic resultValid
);

	// Adder chain between stages
	fp16Pkg::halfWord_t opA;
	fp16Pkg::halfWord_t opB;
	logic issue;
	fp16Pkg::alignedOp_t aligned;
	logic alignedValid;
	fp16Pkg::mantSum_t mantSum;
	logic mantSumValid;
	fp16Pkg::normSum_t normSum;
	logic normValid;
	fp16Pkg::halfWord_t sum;
	logic sumValid;

	accumSequencer seq (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.start(start),
		.continueRun(continueRun),
		.done(done),
		.idle(idle),
		.ready(ready),
		.memAddr(memAddr),
		.memEnable(memEnable),
		.memData(memData),
		.opA(opA),
		.opB(opB),
		.issue(issue),
		.sum(sum),
		.sumValid(sumValid),
		.result(result),
		.resultValid(resultValid)
	);

	fpAlignStage align (.ap_clk(ap_clk), .opA(opA), .opB(opB), .issue(issue),
		.aligned(aligned), .alignedValid(alignedValid));

	fpMantissaAddStage add (.ap_clk(ap_clk), .aligned(aligned), .alignedValid(alignedValid),
		.mantSum(mantSum), .mantSumValid(mantSumValid));

	fpNormalizeStage norm (.ap_clk(ap_clk), .mantSum(mantSum), .mantSumValid(mantSumValid),
		.normSum(normSum), .normValid(normValid));

	fpRoundStage rnd (.ap_clk(ap_clk), .normSum(normSum), .normValid(normValid),
		.sum(sum), .sumValid(sumValid));

endmodule

/* run.sh */
#!/bin/sh
# Build and run the accumulator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tbHalfVectorAccum -o simHalfVectorAccum
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simHalfVectorAccum > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned an error"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
fi
exit 1

/* test/tbHalfVectorAccum.sv */
`include "accum_settings.svh"

module tbHalfVectorAccum;
	import fp16Pkg::*;
	import accumCtrlPkg::*;

	localparam int ExpBias = 15;
	localparam int RunCycles = 1 + (2 + `ADD_LATENCY) * `ACCUM_LEN; // Read, capture, adder per word
	localparam int WaitLimit = 4 * RunCycles; // Cycles before a wait gives up

	logic ap_clk;
	logic ap_rst;
	logic start;
	logic continueRun;
	logic done;
	logic idle;
	logic ready;
	memAddr_t memAddr;
	logic memEnable;
	halfWord_t memData;
	halfWord_t result;
	logic resultValid;

	halfWord_t mem [`ACCUM_LEN]; // Memory model contents
	int vec [`ACCUM_LEN]; // Integer view of the vector
	memAddr_t addrSeen [$]; // Read addresses in issue order
	logic [15:0] lfsr;
	int errCount;
	int testCount;
	int failedTests;
	int errAtStart;

	halfVectorAccum UUT (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.start(start),
		.continueRun(continueRun),
		.done(done),
		.idle(idle),
		.ready(ready),
		.memAddr(memAddr),
		.memEnable(memEnable),
		.memData(memData),
		.result(result),
		.resultValid(resultValid)
	);

	initial begin
		ap_clk = 1'b0;
		forever #2 ap_clk = ~ap_clk;
	end

	// Single-port memory answering one edge after the enable
	always @(posedge ap_clk) begin
		if (memEnable) begin
			memData <= mem[memAddr];
			addrSeen.push_back(memAddr);
		end
	end

	// Done cycle carries all three strobes
	assert property (@(posedge ap_clk) disable iff (ap_rst) resultValid |-> (done && ready))
		else begin
			$display("Fail %0t: resultValid without done and ready", $time);
			errCount++;
		end

	assert property (@(posedge ap_clk) disable iff (ap_rst) (done && !continueRun) |=> done)
		else begin
			$display("Fail %0t: done dropped before continue", $time);
			errCount++;
		end

	// No reads while a result waits for continue
	assert property (@(posedge ap_clk) disable iff (ap_rst) memEnable |-> !done)
		else begin
			$display("Fail %0t: memory read while done was high", $time);
			errCount++;
		end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int randSmall();
		int v;
		v = 0;
		for (int i = 0; i < 7; i++) begin
			lfsr = lfsrStep(lfsr); // one step per bit
			v = (v << 1) | int'(lfsr[0]);
		end
		return v - 64; // -64 to 63
	endfunction

	// Nearest even on integers with an ulp of 2 from 2048 up to 4096
	function automatic int roundInt(input int v);
		int a;
		int q;
		a = (v < 0) ? -v : v;
		if (a >= 2048 && a < 4096) begin
			q = a >> 1;
			if ((a & 1) && (q & 1))
				q++; // Tie goes to the even mantissa
			a = q << 1;
		end
		return (v < 0) ? -a : a;
	endfunction

	function automatic halfWord_t toHalf(input int v);
		halfWord_t h;
		int a;
		int p;
		h = '0;
		a = (v < 0) ? -v : v;
		p = 0;
		for (int i = 0; i < 31; i++) begin
			if ((a >> i) != 0)
				p = i; // Leading one position
		end
		if (a != 0) begin
			h.sign = (v < 0);
			h.exp = `EXP_W'(ExpBias + p);
			if (p <= `MANT_W)
				h.mant = `MANT_W'(a << (`MANT_W - p)); // hidden one truncated away
			else
				h.mant = `MANT_W'(a >> (p - `MANT_W)); // only exact values here
		end
		return h;
	endfunction

	task automatic checkTrue(input logic cond, input string msg);
		assert (cond) else begin
			$display("Fail %0t: %s", $time, msg);
			errCount++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		errCount++;
	endtask

	task automatic beginTest();
		errAtStart = errCount;
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errCount == errAtStart) begin
			$display("[%0t] %s: ok", $time, name);
		end else begin
			failedTests++;
			$display("[%0t] %s: %0d errors", $time, name, errCount - errAtStart);
		end
	endtask

	// Loads vec, runs one accumulation and checks the done cycle
	task automatic runVector();
		int cycles;
		int run;
		halfWord_t want;
		run = 0;
		for (int i = 0; i < `ACCUM_LEN; i++) begin
			mem[i] = toHalf(vec[i]);
			run = roundInt(run + vec[i]); // each partial sum rounded like the adder
		end
		want = toHalf(run);
		addrSeen.delete();
		@(posedge ap_clk);
		start <= 1'b1;
		@(posedge ap_clk); // Taken here since idle and not done
		start <= 1'b0;
		cycles = 0;
		do begin
			@(negedge ap_clk);
			cycles++;
		end while (!done && cycles < WaitLimit);
		if (!done) begin
			reportTimeout("done never rose after start");
		end else begin
			checkTrue(cycles == RunCycles, $sformatf("done after %0d cycles, want %0d",
				cycles, RunCycles));
			checkTrue(ready && resultValid, "ready or resultValid low in the done cycle");
			checkTrue(result == want, $sformatf("result %h, want %h", result, want));
			checkTrue(addrSeen.size() == `ACCUM_LEN, "wrong number of memory reads");
			foreach (addrSeen[i]) begin
				checkTrue(addrSeen[i] == memAddr_t'(i), $sformatf("read %0d at address %0d",
					i, addrSeen[i]));
			end
			@(negedge ap_clk);
			checkTrue(!resultValid && result == want, "result not held after the done cycle");
		end
	endtask

	task automatic releaseDone();
		int cycles;
		@(posedge ap_clk);
		continueRun <= 1'b1;
		@(posedge ap_clk);
		continueRun <= 1'b0;
		cycles = 0;
		do begin
			@(negedge ap_clk);
			cycles++;
		end while (done && cycles < WaitLimit);
		if (done) begin
			reportTimeout("done stayed high after continue");
		end else begin
			checkTrue(idle, "not idle after continue");
		end
	endtask

	initial begin
		ap_rst = 1'b1;
		start = 1'b0;
		continueRun = 1'b0;
		memData = '0;
		lfsr = 16'd25;
		errCount = 0;
		testCount = 0;
		failedTests = 0;
		repeat (10) @(posedge ap_clk);
		ap_rst <= 1'b0;

		beginTest();
		@(negedge ap_clk);
		checkTrue(!done && !ready && !resultValid && !memEnable, "strobe high after reset");
		checkTrue(idle, "idle low after reset");
		checkTrue(result == '0, "result not zero after reset");
		endTest("reset");

		beginTest();
		for (int i = 0; i < `ACCUM_LEN; i++) begin
			vec[i] = randSmall();
		end
		runVector();
		releaseDone();
		endTest("random integers");

		beginTest();
		for (int i = 0; i < `ACCUM_LEN; i += 2) begin
			vec[i] = randSmall();
			vec[i+1] = -vec[i]; // Cancels to +0 every pair
		end
		runVector();
		releaseDone();
		endTest("cancelling pairs");

		beginTest();
		vec = '{2048, 1, 1, 1, 1, 1, 1, 3}; // Ties at 2049 and 2051 round to even
		runVector();
		releaseDone();
		endTest("round to nearest even");

		beginTest();
		for (int i = 0; i < `ACCUM_LEN; i++) begin
			vec[i] = randSmall();
		end
		runVector();
		@(posedge ap_clk);
		start <= 1'b1; // Ignored while done is held
		@(posedge ap_clk);
		start <= 1'b0;
		repeat (6) begin
			@(negedge ap_clk);
			checkTrue(done && !memEnable, "start accepted while done was held");
		end
		checkTrue(idle, "sequencer left idle while done was held");
		releaseDone();
		runVector();
		releaseDone();
		endTest("start while done held");

		$display("Tests run %0d, failed %0d, check errors %0d", testCount, failedTests,
			errCount);
		if (errCount == 0 && failedTests == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
